/* flist.f */
beam_pkg.sv
sample_store.sv
beam_power.sv
dual_beam_trigger.sv
beamform_trigger.sv
tb_beamform_trigger.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_beamform_trigger -f flist.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"

/* tb_beamform_trigger.sv */
module tb_beamform_trigger;
    import beam_pkg::*;

    localparam int NBEAMS = 4;
    localparam int NTRIG = 2 * NBEAMS;
    // Clocks per test in run order, reset first
    localparam int TOTAL_CYCLES = 5 + 20 + 11 + 12 + 33 + 16 + 305;

    logic             clk_i;
    logic             rst_i;
    chan_bus_t        data_i;
    thresh_bus_t      thresh_i;
    logic [1:0]       thresh_wr_i;
    logic [1:0]       thresh_update_i;
    logic [NTRIG-1:0] trigger_o;

    // Model history, index 0 is the newest word
    chan_bus_t hist_m [3];
    // Model power pipeline, index 3 feeds the comparison
    power_t    pipe_m [4][NBEAMS];
    thresh_t   staged_m [NBEAMS][NSETS];
    thresh_t   active_m [NBEAMS][NSETS];

    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          test_errors;

    beamform_trigger #(
        .NBEAMS (NBEAMS)
    ) u_beamform_trigger (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .data_i          (data_i),
        .thresh_i        (thresh_i),
        .thresh_wr_i     (thresh_wr_i),
        .thresh_update_i (thresh_update_i),
        .trigger_o       (trigger_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #4 clk_i = ~clk_i;
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // Upper bits only, the low LCG bits repeat quickly
    function automatic chan_bus_t random_bus();
        chan_bus_t   d;
        logic [31:0] r;
        for (int c = 0; c < NCHAN; c++) begin
            for (int s = 0; s < NSAMP; s++) begin
                r = lcg_next();
                d[c].samp[s] = r[20:16];
            end
        end
        return d;
    endfunction

    // Thresholds in the range of typical random powers
    function automatic thresh_t random_thresh();
        return thresh_t'(lcg_next() >> 19);
    endfunction

    // Constant in time, +amp or -amp around mid-scale per channel
    function automatic chan_bus_t pattern_bus(input int amp, input logic [NCHAN-1:0] neg);
        chan_bus_t d;
        for (int c = 0; c < NCHAN; c++) begin
            for (int s = 0; s < NSAMP; s++) begin
                d[c].samp[s] = NBITS'(neg[c] ? 16 - amp : 16 + amp);
            end
        end
        return d;
    endfunction

    function automatic thresh_t set_field(input thresh_bus_t t, input int k);
        return (k == 0) ? t.set0 : t.set1;
    endfunction

    // Beam power by the table rules, window ending at the newest model word
    function automatic power_t power_model(input int b);
        beam_cfg_t cfg;
        int        idx;
        int        w;
        int        pos;
        int        v;
        int        sum;
        int        acc;
        cfg = BEAM_CFG[b];
        acc = 0;
        for (int s = 0; s < NSAMP; s++) begin
            sum = 0;
            for (int c = 0; c < NCHAN; c++) begin
                // Sample index relative to the newest word, negative reaches back
                idx = s - int'(cfg.delay[c]);
                w = (3 - idx) / 4;
                pos = idx + 4 * w;
                v = int'(hist_m[w][c].samp[pos]) - 16;
                if (!cfg.use_mask[c]) begin
                    v = 0;
                end else if (cfg.inv_mask[c]) begin
                    v = -v;
                end
                sum += v;
            end
            acc += sum * sum;
        end
        return power_t'(acc);
    endfunction

    task automatic check_trigger(input logic [NTRIG-1:0] got, input logic [NTRIG-1:0] want,
                                 input string msg);
        checks++;
        if (got !== want) begin
            errors++;
            test_errors++;
            $display("FAILED at %0t: %s, trigger_o expected %b got %b", $time, msg, want, got);
        end
    endtask

    task automatic check_power_model(input power_t got, input power_t want, input string msg);
        checks++;
        if (got !== want) begin
            errors++;
            test_errors++;
            $display("FAILED at %0t: %s, power expected %0d got %0d", $time, msg, want, got);
        end
    endtask

    task automatic finish_test(input string name);
        $display("Test %s done with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic reset_dut();
        rst_i = 1'b1;
        data_i = '0;
        thresh_i = '0;
        thresh_wr_i = '0;
        thresh_update_i = '0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        for (int w = 0; w < 3; w++) begin
            hist_m[w] = '0;
        end
        for (int b = 0; b < NBEAMS; b++) begin
            for (int k = 0; k < NSETS; k++) begin
                staged_m[b][k] = '1;
                active_m[b][k] = '1;
            end
            for (int p = 1; p < 4; p++) begin
                pipe_m[p][b] = '0;
            end
            // First real power comes from the cleared history
            pipe_m[0][b] = power_model(b);
        end
    endtask

    // One clock: drive, advance the model, check trigger_o after the edge
    task automatic step(input chan_bus_t d, input logic [1:0] wr, input logic [1:0] upd,
                        input thresh_bus_t th);
        logic [NTRIG-1:0] want;
        data_i = d;
        thresh_i = th;
        thresh_wr_i = wr;
        thresh_update_i = upd;
        hist_m[2] = hist_m[1];
        hist_m[1] = hist_m[0];
        hist_m[0] = d;
        for (int b = 0; b < NBEAMS; b++) begin
            for (int k = 0; k < NSETS; k++) begin
                want[k*NBEAMS+b] = {1'b0, pipe_m[3][b]} > active_m[b][k];
            end
            for (int p = 3; p > 0; p--) begin
                pipe_m[p][b] = pipe_m[p-1][b];
            end
            pipe_m[0][b] = power_model(b);
        end
        for (int k = 0; k < NSETS; k++) begin
            if (upd[k]) begin
                for (int b = 0; b < NBEAMS; b++) begin
                    active_m[b][k] = staged_m[b][k];
                end
            end
            // Chain moves away from beam 0
            if (wr[k]) begin
                for (int b = NBEAMS - 1; b > 0; b--) begin
                    staged_m[b][k] = staged_m[b-1][k];
                end
                staged_m[0][k] = set_field(th, k);
            end
        end
        @(posedge clk_i);
        #1;
        check_trigger(trigger_o, want, "model compare");
    endtask

    // Four writes to set k, v[0] goes first and ends in beam 3
    task automatic load_set(input int k, input thresh_t [3:0] v, input chan_bus_t d);
        thresh_bus_t th;
        logic [1:0]  wr;
        wr = '0;
        wr[k] = 1'b1;
        for (int i = 0; i < 4; i++) begin
            th = '0;
            if (k == 0) begin
                th.set0 = v[i];
            end else begin
                th.set1 = v[i];
            end
            step(d, wr, 2'b00, th);
        end
    endtask

    task automatic test_reset_quiet();
        for (int i = 0; i < 20; i++) begin
            step(pattern_bus(15, '0), 2'b00, 2'b00, '0);
            check_trigger(trigger_o, '0, "quiet before any update");
        end
        finish_test("reset_quiet");
    endtask

    task automatic test_thresh_order();
        chan_bus_t d;
        d = pattern_bus(2, '0);
        load_set(0, {18'd1023, 18'd1024, 18'd255, 18'd0}, d);
        step(d, 2'b00, 2'b01, '0);
        repeat (6) step(d, 2'b00, 2'b00, '0);
        // All eight in phase give 256*a*a, beam 2 keeps 4a, beam 3 cancels
        check_power_model(power_model(0), 17'd1024, "beam 0 level");
        check_power_model(power_model(1), 17'd1024, "beam 1 level");
        check_power_model(power_model(2), 17'd256, "beam 2 level");
        check_power_model(power_model(3), 17'd0, "beam 3 level");
        check_trigger(trigger_o, 8'b0000_0101, "set 0 order");
        finish_test("thresh_order");
    endtask

    task automatic test_staged_hold();
        chan_bus_t d;
        d = pattern_bus(2, '0);
        load_set(0, {18'd2000, 18'd1000, 18'd300, 18'd0}, d);
        repeat (4) step(d, 2'b00, 2'b00, '0);
        // Old active values still rule
        check_trigger(trigger_o, 8'b0000_0101, "staged without update");
        step(d, 2'b00, 2'b01, '0);
        repeat (3) step(d, 2'b00, 2'b00, '0);
        check_trigger(trigger_o, 8'b0000_0010, "after update");
        finish_test("staged_hold");
    endtask

    task automatic impulse_run(input int ch, input int sp);
        chan_bus_t        d;
        logic [NTRIG-1:0] want;
        int               due;
        for (int i = 0; i < 12; i++) begin
            d = pattern_bus(0, '0);
            if (i == 0) begin
                d[ch].samp[sp] = 5'd31;
            end
            step(d, 2'b00, 2'b00, '0);
            want = '0;
            for (int b = 0; b < NBEAMS; b++) begin
                // Word whose window holds the impulse, plus four clocks latency
                due = (sp + int'(BEAM_CFG[b].delay[ch])) / 4 + 4;
                if (BEAM_CFG[b].use_mask[ch] && i == due) begin
                    want[b] = 1'b1;
                end
            end
            check_trigger(trigger_o, want, "impulse arrival");
        end
    endtask

    task automatic test_impulse();
        chan_bus_t quiet;
        quiet = pattern_bus(0, '0);
        load_set(0, {4{18'd100}}, quiet);
        step(quiet, 2'b00, 2'b01, '0);
        repeat (4) step(quiet, 2'b00, 2'b00, '0);
        impulse_run(3, 1);
        // Channel 6 lies outside beam 2's mask
        impulse_run(6, 2);
        finish_test("impulse");
    endtask

    task automatic test_inversion();
        chan_bus_t d;
        // Upper half negative, only beam 3 flips it back into phase
        d = pattern_bus(4, 8'hF0);
        repeat (8) step(d, 2'b00, 2'b00, '0);
        check_trigger(trigger_o, 8'b0000_1000, "upper half negative");
        // Odd channels negative, the flip on channel 1 leaves beam 2 a net sum
        d = pattern_bus(4, 8'hAA);
        repeat (8) step(d, 2'b00, 2'b00, '0);
        check_trigger(trigger_o, 8'b0000_0100, "odd channels negative");
        finish_test("inversion");
    endtask

    task automatic test_random();
        thresh_bus_t th;
        logic [1:0]  wr;
        logic [1:0]  upd;
        // Both sets shift together, then one shared update
        for (int i = 0; i < 4; i++) begin
            th.set0 = random_thresh();
            th.set1 = random_thresh();
            step(random_bus(), 2'b11, 2'b00, th);
        end
        step(random_bus(), 2'b00, 2'b11, '0);
        for (int i = 0; i < 300; i++) begin
            wr = '0;
            upd = '0;
            th = '0;
            // Reload one set now and then while data keeps flowing
            if (i % 50 >= 10 && i % 50 < 14) begin
                wr[(i/50)%2] = 1'b1;
                th.set0 = random_thresh();
                th.set1 = random_thresh();
            end
            if (i % 50 == 20) begin
                upd[(i/50)%2] = 1'b1;
            end
            step(random_bus(), wr, upd, th);
        end
        finish_test("random");
    endtask

    initial begin
        rng_state = 32'd19;
        errors = 0;
        checks = 0;
        test_errors = 0;
        rst_i = 1'b1;
        data_i = '0;
        thresh_i = '0;
        thresh_wr_i = '0;
        thresh_update_i = '0;
        reset_dut();
        test_reset_quiet();
        test_thresh_order();
        test_staged_hold();
        test_impulse();
        test_inversion();
        test_random();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog, test length plus a margin
    initial begin
        #(TOTAL_CYCLES * 8 + 800);
        $display("Timeout: the tests did not finish within %0d cycles", TOTAL_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* beamform_trigger.sv */
module beamform_trigger #(
    parameter int NBEAMS = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  beam_pkg::chan_bus_t    data_i,
    input  beam_pkg::thresh_bus_t  thresh_i,
    input  logic [1:0]             thresh_wr_i,
    input  logic [1:0]             thresh_update_i,
    output logic [2*NBEAMS-1:0]    trigger_o
);
    import beam_pkg::*;

    localparam int NPAIRS = NBEAMS / 2;

    // Delayed window per beam
    chan_bus_t beam_win [NBEAMS];

    // Entry p of the threshold chain feeds pair p
    thresh_bus_t casc [NPAIRS+1];

    // Pair bits in the order A set 0, A set 1, B set 0, B set 1
    logic [3:0] pair_trig [NPAIRS];

    sample_store #(
        .NBEAMS (NBEAMS)
    ) u_sample_store (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .data_i     (data_i),
        .beam_win_o (beam_win)
    );

    // Nothing feeds the first pair from behind
    assign casc[0] = '0;

    for (genvar p = 0; p < NPAIRS; p++) begin : g_pair
        dual_beam_trigger #(
            .BEAM_BASE (2*p)
        ) u_dual_beam_trigger (
            .clk_i           (clk_i),
            .rst_i           (rst_i),
            .win_a_i         (beam_win[2*p]),
            .win_b_i         (beam_win[2*p+1]),
            .thresh_i        (thresh_i),
            .thresh_wr_i     (thresh_wr_i),
            .thresh_update_i (thresh_update_i),
            .casc_i          (casc[p]),
            .casc_o          (casc[p+1]),
            .trigger_o       (pair_trig[p])
        );

        // Set 0 bits go in the low half and set 1 bits in the high half
        assign trigger_o[2*p]            = pair_trig[p][0];
        assign trigger_o[2*p+1]          = pair_trig[p][2];
        assign trigger_o[NBEAMS+2*p]     = pair_trig[p][1];
        assign trigger_o[NBEAMS+2*p+1]   = pair_trig[p][3];
    end

endmodule

/* dual_beam_trigger.sv */
module dual_beam_trigger #(
    parameter int BEAM_BASE = 0
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  beam_pkg::chan_bus_t    win_a_i,
    input  beam_pkg::chan_bus_t    win_b_i,
    input  beam_pkg::thresh_bus_t  thresh_i,
    input  logic [1:0]             thresh_wr_i,
    input  logic [1:0]             thresh_update_i,
    input  beam_pkg::thresh_bus_t  casc_i,
    output beam_pkg::thresh_bus_t  casc_o,
    output logic [3:0]             trigger_o
);
    import beam_pkg::*;

    // Index 0 is beam A, index 1 is beam B
    thresh_t [NSETS-1:0] staged [2];
    thresh_t [NSETS-1:0] active [2];

    // Head of the chain for this pair
    thresh_t [NSETS-1:0] chain_in;

    power_t     power_a;
    power_t     power_b;
    logic [3:0] trig_q;

    // First pair takes the serial input, the rest follow the previous pair
    assign chain_in = (BEAM_BASE == 0) ? thresh_i : casc_i;

    beam_power u_beam_a (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .win_i   (win_a_i),
        .cfg_i   (BEAM_CFG[BEAM_BASE]),
        .power_o (power_a)
    );

    beam_power u_beam_b (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .win_i   (win_b_i),
        .cfg_i   (BEAM_CFG[BEAM_BASE+1]),
        .power_o (power_b)
    );

    // Staging chain and active copy, each set handled on its own strobes
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // All ones keeps every beam quiet until loaded
            for (int b = 0; b < 2; b++) begin
                staged[b] <= '1;
                active[b] <= '1;
            end
        end else begin
            for (int k = 0; k < NSETS; k++) begin
                if (thresh_wr_i[k]) begin
                    staged[0][k] <= chain_in[k];
                    staged[1][k] <= staged[0][k];
                end
                if (thresh_update_i[k]) begin
                    active[0][k] <= staged[0][k];
                    active[1][k] <= staged[1][k];
                end
            end
        end
    end

    // Tail of the chain goes on to the next pair
    assign casc_o = staged[1];

    // Registered comparators, strictly above threshold
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            trig_q <= '0;
        end else begin
            trig_q[0] <= {1'b0, power_a} > active[0][0];
            trig_q[1] <= {1'b0, power_a} > active[0][1];
            trig_q[2] <= {1'b0, power_b} > active[1][0];
            trig_q[3] <= {1'b0, power_b} > active[1][1];
        end
    end

    assign trigger_o = trig_q;

    // Shift and copy of one set never share a clock
    for (genvar k = 0; k < NSETS; k++) begin : g_set_chk
        a_wr_upd_excl: assert property (@(posedge clk_i) disable iff (rst_i)
            !(thresh_wr_i[k] && thresh_update_i[k]));
    end

endmodule

/* beam_power.sv */
module beam_power (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  beam_pkg::chan_bus_t  win_i,
    input  beam_pkg::beam_cfg_t  cfg_i,
    output beam_pkg::power_t     power_o
);
    import beam_pkg::*;

    // Sum of 8 channels, -128 to 128
    localparam int SUM_BITS = 9;
    // Square of one sum, at most 16384
    localparam int SQ_BITS = 15;

    logic signed [SUM_BITS-1:0]   sum_d [NSAMP];
    logic signed [SUM_BITS-1:0]   sum_q [NSAMP];
    logic signed [2*SUM_BITS-1:0] sq_d  [NSAMP];
    logic        [SQ_BITS-1:0]    sq_q  [NSAMP];
    power_t                       power_q;

    // Offset binary to signed, then flip or drop per channel
    function automatic logic signed [5:0] conv_sample(
        input logic [NBITS-1:0] raw,
        input logic             inv,
        input logic             use_bit
    );
        logic signed [5:0] val;
        val = $signed({1'b0, raw}) - 6'sd16;
        if (!use_bit) begin
            val = '0;
        end else if (inv) begin
            val = -val;
        end
        return val;
    endfunction

    // Stage 1 input, channel sum per sample
    always_comb begin : sum_comb
        logic signed [SUM_BITS-1:0] acc;
        for (int s = 0; s < NSAMP; s++) begin
            acc = '0;
            for (int c = 0; c < NCHAN; c++) begin
                acc = acc + SUM_BITS'(conv_sample(win_i[c].samp[s],
                                                  cfg_i.inv_mask[c],
                                                  cfg_i.use_mask[c]));
            end
            sum_d[s] = acc;
        end
    end

    // Stage 2 input, full width products
    always_comb begin
        for (int s = 0; s < NSAMP; s++) begin
            sq_d[s] = sum_q[s] * sum_q[s];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < NSAMP; s++) begin
                sum_q[s] <= '0;
                sq_q[s]  <= '0;
            end
            power_q <= '0;
        end else begin
            for (int s = 0; s < NSAMP; s++) begin
                sum_q[s] <= sum_d[s];
                // Square is never negative and fits 15 bits
                sq_q[s]  <= SQ_BITS'(sq_d[s]);
            end
            // Stage 3, one power value per clock
            power_q <= power_t'(sq_q[0]) + power_t'(sq_q[1]) +
                       power_t'(sq_q[2]) + power_t'(sq_q[3]);
        end
    end

    assign power_o = power_q;

endmodule

/* sample_store.sv */
module sample_store #(
    parameter int NBEAMS = 4
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  beam_pkg::chan_bus_t data_i,
    output beam_pkg::chan_bus_t beam_win_o [NBEAMS]
);
    import beam_pkg::*;

    // Word 0 is the last registered clock, kept in the top bits
    chan_word_t [0:STORE_WORDS-1] hist [NCHAN];

    // Same history seen as one run of samples, oldest at bit 0
    logic [STORE_WORDS*NSAMP*NBITS-1:0] flat [NCHAN];

    // History shift, one word per clock
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int c = 0; c < NCHAN; c++) begin
                hist[c] <= '0;
            end
        end else begin
            for (int c = 0; c < NCHAN; c++) begin
                hist[c][0] <= data_i[c];
                for (int w = 1; w < STORE_WORDS; w++) begin
                    hist[c][w] <= hist[c][w-1];
                end
            end
        end
    end

    for (genvar c = 0; c < NCHAN; c++) begin : g_flat
        assign flat[c] = hist[c];
    end

    for (genvar b = 0; b < NBEAMS; b++) begin : g_beam
        for (genvar c = 0; c < NCHAN; c++) begin : g_chan
            // Table delay for this beam and channel
            localparam int DLY = int'(BEAM_CFG[b].delay[c]);
            // Delay 0 lands on the start of word 0
            localparam int OFS = (STORE_WORDS - 1) * NSAMP - DLY;

            assign beam_win_o[b][c] = flat[c][OFS*NBITS +: NSAMP*NBITS];

            // Used channels must reach no further back than the history
            a_delay_range: assert property (@(posedge clk_i) disable iff (rst_i)
                !BEAM_CFG[b].use_mask[c] || (DLY <= MAX_DELAY));
        end
    end

endmodule

/* beam_pkg.sv */
package beam_pkg;

    // Input geometry
    localparam int NCHAN = 8;
    localparam int NSAMP = 4;
    localparam int NBITS = 5;

    // Largest delay in the beam table, in samples
    localparam int MAX_DELAY = 8;
    // Words of history kept per channel, enough for MAX_DELAY behind the last word
    localparam int STORE_WORDS = 3;

    localparam int BEAM_TOTAL = 4;

    localparam int THRESH_BITS = 18;
    // 4 squares of a sum of 8 values up to 16 in magnitude
    localparam int POWER_BITS = 17;
    localparam int NSETS = 2;

    // One clock of one channel, sample 0 is the oldest
    typedef struct packed {
        logic [NSAMP-1:0][NBITS-1:0] samp;
    } chan_word_t;

    // All channels for one clock
    typedef chan_word_t [NCHAN-1:0] chan_bus_t;

    typedef logic [THRESH_BITS-1:0] thresh_t;

    // Set 0 is the trigger level, set 1 the secondary level
    typedef struct packed {
        thresh_t set1;
        thresh_t set0;
    } thresh_bus_t;

    typedef logic [POWER_BITS-1:0] power_t;

    // Per-beam steering, channel 0 in the low bits of every field
    typedef struct packed {
        logic [NCHAN-1:0][3:0] delay;
        logic [NCHAN-1:0]      use_mask;
        logic [NCHAN-1:0]      inv_mask;
    } beam_cfg_t;

    // Delays listed channel 7 first
    localparam beam_cfg_t BEAM_CFG [BEAM_TOTAL] = '{
        // Broadside
        '{delay: {4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0},
          use_mask: 8'hFF, inv_mask: 8'h00},
        // Linear ramp up
        '{delay: {4'd7, 4'd6, 4'd5, 4'd4, 4'd3, 4'd2, 4'd1, 4'd0},
          use_mask: 8'hFF, inv_mask: 8'h00},
        // Ramp down, channels 6 and 7 off, channel 1 flipped
        '{delay: {4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8},
          use_mask: 8'h3F, inv_mask: 8'h02},
        // Peaked at channel 4, upper half flipped
        '{delay: {4'd2, 4'd4, 4'd6, 4'd8, 4'd6, 4'd4, 4'd2, 4'd0},
          use_mask: 8'hFF, inv_mask: 8'hF0}
    };

endpackage
